//--- icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ==================================================
// Cache geometry
// ==================================================

`define ICACHE_SETS        8  // Power of two
`define ICACHE_LINE_WORDS  4  // Power of two

// Must track the two sizes above
`define ICACHE_INDEX_BITS  3
`define ICACHE_OFFSET_BITS 2

`endif

//--- icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

  localparam int TAG_BITS = 32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS - 2;

  typedef logic [1:0] way_t;

  typedef logic [3:0][TAG_BITS-1:0] tag_vec_t;  // One tag per way

  typedef struct packed {
    logic [TAG_BITS-1:0]            tag;
    logic [`ICACHE_INDEX_BITS-1:0]  index;
    logic [`ICACHE_OFFSET_BITS-1:0] word;
    logic [1:0]                     byte_off;
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } fetch_addr_u;

  typedef struct packed {
    logic        valid;
    fetch_addr_u addr;
  } fetch_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } fetch_rsp_t;

  // Read-only Wishbone classic
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic        valid;
    fetch_addr_u addr;
    logic        hit;
    logic [3:0]  way_hit;     // One-hot
    logic [2:0]  lru;         // Tree bits as read at lookup
    logic [3:0]  valid_ways;
  } lookup_reg_t;

endpackage

//--- icache_tag_store.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_tag_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`ICACHE_INDEX_BITS-1:0]       rd_index,
  output icache_pkg::tag_vec_t                rd_tags,
  output logic [3:0]                          rd_valid,
  output logic [2:0]                          rd_lru,
  input  logic [`ICACHE_INDEX_BITS-1:0]       wr_index,
  input  icache_pkg::way_t                    wr_way,
  input  logic                                tag_we,
  input  logic [icache_pkg::TAG_BITS-1:0]     tag_data,
  input  logic                                valid_we,
  input  logic                                lru_we,
  input  logic [2:0]                          lru_data,
  output logic                                init_busy
);

  icache_pkg::tag_vec_t                tag_mem [`ICACHE_SETS];
  logic [3:0]                          valid_mem [`ICACHE_SETS];
  logic [2:0]                          lru_mem [`ICACHE_SETS];
  logic [`ICACHE_INDEX_BITS-1:0]       init_index;

  // ==================================================
  // Clear sweep after reset, one set per cycle
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_busy  <= 1'b1;
      init_index <= '0;
    end
    else if (init_busy)
    begin
      init_index <= init_index + 1'b1;
      if (init_index == '1)  // Last set
        init_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (init_busy)
    begin
      valid_mem[init_index] <= '0;
      lru_mem[init_index]   <= '0;
    end
    else
    begin
      if (valid_we)
        valid_mem[wr_index][wr_way] <= 1'b1;
      if (lru_we)
        lru_mem[wr_index] <= lru_data;
    end
    if (tag_we)
      tag_mem[wr_index][wr_way] <= tag_data;
  end

  assign rd_tags  = tag_mem[rd_index];
  assign rd_valid = valid_mem[rd_index];
  assign rd_lru   = (lru_we && (wr_index == rd_index)) ? lru_data : lru_mem[rd_index];  // Bypass

  assert property (@(posedge clk) disable iff (rst)
    init_busy |-> !(tag_we || valid_we || lru_we));

endmodule

//--- icache_data_store.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_data_store (
  input  logic                            clk,
  input  logic [`ICACHE_INDEX_BITS-1:0]   rd_index,
  input  logic [`ICACHE_OFFSET_BITS-1:0]  rd_offset,
  input  icache_pkg::way_t                rd_way,
  output logic [31:0]                     rd_data,
  input  logic [`ICACHE_INDEX_BITS-1:0]   wr_index,
  input  icache_pkg::way_t                wr_way,
  input  logic [`ICACHE_OFFSET_BITS-1:0]  wr_offset,
  input  logic [31:0]                     wr_data,
  input  logic                            data_we
);

  localparam int ADDR_BITS = 2 + `ICACHE_INDEX_BITS + `ICACHE_OFFSET_BITS;
  localparam int DEPTH     = 4 * `ICACHE_SETS * `ICACHE_LINE_WORDS;

  logic [31:0]          mem [DEPTH];
  logic [ADDR_BITS-1:0] rd_addr;
  logic [ADDR_BITS-1:0] wr_addr;

  // Word address is way, set, word
  assign rd_addr = {rd_way, rd_index, rd_offset};
  assign wr_addr = {wr_way, wr_index, wr_offset};

  assign rd_data = mem[rd_addr];

  always_ff @(posedge clk)
  begin
    if (data_we)
      mem[wr_addr] <= wr_data;  // One word per ack
  end

endmodule

//--- icache_lookup.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_lookup (
  input  logic                           clk,
  input  logic                           rst,
  input  icache_pkg::fetch_req_t         req,
  input  logic                           take,
  input  logic                           replay,
  input  icache_pkg::tag_vec_t           tags,
  input  logic [3:0]                     valids,
  input  logic [2:0]                     lru,
  output logic [`ICACHE_INDEX_BITS-1:0]  index,
  output icache_pkg::lookup_reg_t        stage
);

  icache_pkg::fetch_addr_u cmp_addr;
  logic                    cmp_valid;
  logic [3:0]              way_hit;

  always_comb
  begin
    cmp_addr  = replay ? stage.addr : req.addr;  // Replay looks up the held address
    cmp_valid = replay ? stage.valid : req.valid;
  end

  assign index = cmp_addr.f.index;

  always_comb
  begin
    for (int w = 0; w < 4; w++)
    begin
      way_hit[w] = cmp_valid && valids[w] && (tags[w] == cmp_addr.f.tag);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      stage <= '0;
    else if (take || replay)
    begin
      stage.valid      <= cmp_valid;
      stage.addr       <= cmp_addr;
      stage.hit        <= |way_hit;
      stage.way_hit    <= way_hit;
      stage.lru        <= lru;
      stage.valid_ways <= valids;
    end
  end

  // A line is never filled into a set twice
  assert property (@(posedge clk) disable iff (rst) $onehot0(stage.way_hit));

endmodule

//--- icache_control.sv
`timescale 1ns/10ps

module icache_control (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::lookup_reg_t  stage,
  input  logic                     ready,
  input  logic                     init_busy,
  input  logic                     fill_done,
  output logic                     take,
  output logic                     replay,
  output logic                     stall,
  output logic                     rsp_valid,
  output icache_pkg::way_t         hit_way,
  output logic                     fill_start,
  output icache_pkg::way_t         fill_way,
  output logic                     tag_we,
  output logic                     valid_we,
  output logic                     lru_we,
  output logic [2:0]               lru_data
);

  typedef enum logic [1:0] {IDLE, MISS, HIT} state_t;

  state_t           state;
  state_t           next_state;
  icache_pkg::way_t victim;
  logic             miss;
  logic             start_miss;

  assign miss       = stage.valid && !stage.hit;
  assign start_miss = (state == IDLE) && miss;

  // ==================================================
  // Victim and tree update
  // ==================================================
  always_comb
  begin
    if (!stage.valid_ways[0])
      victim = 2'd0;
    else if (!stage.valid_ways[1])
      victim = 2'd1;
    else if (!stage.valid_ways[2])
      victim = 2'd2;
    else if (!stage.valid_ways[3])
      victim = 2'd3;
    else if (!stage.lru[2])
      victim = stage.lru[0] ? 2'd2 : 2'd3;  // Pair 2/3
    else
      victim = stage.lru[1] ? 2'd0 : 2'd1;  // Pair 0/1
  end

  always_comb
  begin
    case (stage.way_hit)
      4'b0010: hit_way = 2'd1;
      4'b0100: hit_way = 2'd2;
      4'b1000: hit_way = 2'd3;
      default: hit_way = 2'd0;
    endcase
  end

  always_comb
  begin
    case (hit_way)
      2'd0:    lru_data = {2'b00, stage.lru[0]};
      2'd1:    lru_data = {2'b01, stage.lru[0]};
      2'd2:    lru_data = {1'b1, stage.lru[1], 1'b0};
      default: lru_data = {1'b1, stage.lru[1], 1'b1};
    endcase
  end

  // ==================================================
  // State machine
  // ==================================================
  always_comb
  begin
    next_state = state;
    stall      = 1'b1;
    replay     = 1'b0;
    rsp_valid  = 1'b0;
    lru_we     = 1'b0;
    tag_we     = 1'b0;
    valid_we   = 1'b0;
    case (state)
      IDLE:
      begin
        if (stage.valid && stage.hit)
        begin
          rsp_valid = 1'b1;
          lru_we    = ready;  // Update once, on acceptance
          stall     = !ready;
        end
        else if (miss)
          next_state = MISS;
        else
          stall = init_busy;
      end
      MISS:
      begin
        if (fill_done)
        begin
          tag_we     = 1'b1;
          valid_we   = 1'b1;
          next_state = HIT;
        end
      end
      HIT:
      begin
        replay     = 1'b1;
        next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  assign take = !stall;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= IDLE;
      fill_start <= 1'b0;
    end
    else
    begin
      state      <= next_state;
      fill_start <= start_miss;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_miss)
      fill_way <= victim;
  end

  assert property (@(posedge clk) disable iff (rst)
    fill_start |=> (!fill_start until_with fill_done));

endmodule

//--- icache_line_fill.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_line_fill (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  icache_pkg::way_t                way,
  input  icache_pkg::fetch_addr_u         addr,
  output icache_pkg::wb_m2s_t             wb_o,
  input  icache_pkg::wb_s2m_t             wb_i,
  output logic                            data_we,
  output logic [`ICACHE_OFFSET_BITS-1:0]  wr_offset,
  output logic [31:0]                     wr_data,
  output icache_pkg::way_t                wr_way,
  output logic                            done
);

  logic                                                  active;
  logic [`ICACHE_OFFSET_BITS-1:0]                        word_cnt;
  logic [icache_pkg::TAG_BITS+`ICACHE_INDEX_BITS-1:0]    line_base;
  logic                                                  word_ack;

  assign word_ack  = active && wb_i.ack;
  assign data_we   = word_ack;
  assign wr_offset = word_cnt;
  assign wr_data   = wb_i.dat;
  assign done      = word_ack && (word_cnt == '1);  // Last word of the line

  always_comb
  begin
    wb_o.cyc = active;
    wb_o.stb = active;
    wb_o.adr = {line_base, word_cnt, 2'b00};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active   <= 1'b0;
      word_cnt <= '0;
    end
    else if (start)
    begin
      active   <= 1'b1;
      word_cnt <= '0;
    end
    else if (word_ack)
    begin
      word_cnt <= word_cnt + 1'b1;
      if (done)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      line_base <= {addr.f.tag, addr.f.index};
      wr_way    <= way;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

endmodule

//--- icache_top.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::fetch_req_t  fetch_req,
  input  logic                    ready,
  output icache_pkg::fetch_rsp_t  fetch_rsp,
  output logic                    stall,
  output icache_pkg::wb_m2s_t     wb_o,
  input  icache_pkg::wb_s2m_t     wb_i
);

  icache_pkg::lookup_reg_t             stage;
  logic [`ICACHE_INDEX_BITS-1:0]       lookup_index;
  icache_pkg::tag_vec_t                tags;
  logic [3:0]                          valids;
  logic [2:0]                          lru;
  logic                                init_busy;
  logic                                take;
  logic                                replay;
  logic                                rsp_valid;
  icache_pkg::way_t                    hit_way;
  logic                                fill_start;
  icache_pkg::way_t                    fill_way;
  logic                                fill_done;
  logic                                tag_we;
  logic                                valid_we;
  logic                                lru_we;
  logic [2:0]                          lru_data;
  logic                                data_we;
  logic [`ICACHE_OFFSET_BITS-1:0]      wr_offset;
  logic [31:0]                         wr_data;
  icache_pkg::way_t                    wr_way;
  logic [31:0]                         rd_data;

  assign fetch_rsp = '{valid: rsp_valid, data: rd_data};

  icache_tag_store icache_tag_store_inst (
    .clk(clk), .rst(rst),
    .rd_index(lookup_index), .rd_tags(tags), .rd_valid(valids), .rd_lru(lru),
    .wr_index(stage.addr.f.index), .wr_way(fill_way),
    .tag_we(tag_we), .tag_data(stage.addr.f.tag), .valid_we(valid_we),
    .lru_we(lru_we), .lru_data(lru_data), .init_busy(init_busy)
  );

  icache_data_store icache_data_store_inst (
    .clk(clk),
    .rd_index(stage.addr.f.index), .rd_offset(stage.addr.f.word), .rd_way(hit_way),
    .rd_data(rd_data),
    .wr_index(stage.addr.f.index), .wr_way(wr_way), .wr_offset(wr_offset),
    .wr_data(wr_data), .data_we(data_we)
  );

  icache_lookup icache_lookup_inst (
    .clk(clk), .rst(rst), .req(fetch_req), .take(take), .replay(replay),
    .tags(tags), .valids(valids), .lru(lru), .index(lookup_index), .stage(stage)
  );

  icache_control icache_control_inst (
    .clk(clk), .rst(rst), .stage(stage), .ready(ready), .init_busy(init_busy),
    .fill_done(fill_done), .take(take), .replay(replay), .stall(stall),
    .rsp_valid(rsp_valid), .hit_way(hit_way), .fill_start(fill_start),
    .fill_way(fill_way), .tag_we(tag_we), .valid_we(valid_we),
    .lru_we(lru_we), .lru_data(lru_data)
  );

  icache_line_fill icache_line_fill_inst (
    .clk(clk), .rst(rst), .start(fill_start), .way(fill_way), .addr(stage.addr),
    .wb_o(wb_o), .wb_i(wb_i), .data_we(data_we), .wr_offset(wr_offset),
    .wr_data(wr_data), .wr_way(wr_way), .done(fill_done)
  );

endmodule

//--- icache_checker.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module icache_checker #(
  parameter logic [31:0] DATA_PATTERN = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::fetch_req_t  fetch_req,
  input  logic                    ready,
  input  icache_pkg::fetch_rsp_t  fetch_rsp,
  input  logic                    stall,
  input  icache_pkg::wb_m2s_t     wb_o,
  input  icache_pkg::wb_s2m_t     wb_i,
  output int                      data_errors,
  output int                      hit_errors,
  output int                      bus_errors,
  output int                      protocol_errors,
  output int                      outstanding
);

  localparam int LINE_BYTES = 4 * `ICACHE_LINE_WORDS;
  localparam int LOW_BITS   = 2 + `ICACHE_OFFSET_BITS;

  logic [31:0] sh_tag [`ICACHE_SETS][4];  // Address bits above the index
  logic [3:0]  sh_valid [`ICACHE_SETS];
  logic [2:0]  sh_lru [`ICACHE_SETS];
  logic [31:0] q_addr [$];
  logic        q_hit [$];
  logic        latency_check;
  logic        latency_hit;
  logic        hold_pending;
  logic [31:0] held_data;
  logic [31:0] fill_base;
  int          fill_left;
  int          init_left;
  logic        exp_stall;
  int          set_idx;
  logic [31:0] line_tag;
  int          way;
  logic        hit;
  logic [31:0] rsp_addr;
  logic        rsp_hit;

  // Memory model answers every word with its address scrambled
  function automatic logic [31:0] expected_data(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ DATA_PATTERN;
  endfunction

  function automatic int pick_victim(input logic [3:0] valid, input logic [2:0] lru);
    for (int w = 0; w < 4; w++)
      if (!valid[w])
        return w;
    if (!lru[2])
      return lru[0] ? 2 : 3;
    return lru[1] ? 0 : 1;
  endfunction

  function automatic logic [2:0] lru_after_use(input logic [2:0] lru, input int w);
    logic [2:0] nxt;
    nxt    = lru;
    nxt[2] = (w >= 2);
    if (w < 2)
      nxt[1] = (w == 1);
    else
      nxt[0] = (w == 3);
    return nxt;
  endfunction

  // ==================================================
  // Sampled at the falling edge, away from all drives
  // ==================================================
  always @(negedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        sh_valid[s] = '0;
        sh_lru[s]   = '0;
      end
      q_addr.delete();
      q_hit.delete();
      latency_check = 1'b0;
      hold_pending  = 1'b0;
      fill_left     = 0;
      init_left     = `ICACHE_SETS;  // Valid bits clear after reset
      if ({fetch_rsp.valid, wb_o.cyc, wb_o.stb} !== 3'b000)
      begin
        $display("FAILED time %0t: {fetch_rsp.valid,wb_o.cyc,wb_o.stb} expected 000 actual %b",
                 $time, {fetch_rsp.valid, wb_o.cyc, wb_o.stb});
        protocol_errors++;
      end
    end
    else
    begin
      if (latency_check && (fetch_rsp.valid !== latency_hit))  // Hit answers next cycle
      begin
        $display("FAILED time %0t: fetch_rsp.valid expected %0b actual %0b",
                 $time, latency_hit, fetch_rsp.valid);
        hit_errors++;
      end
      latency_check = 1'b0;
      if (hold_pending && ((fetch_rsp.valid !== 1'b1) || (fetch_rsp.data !== held_data)))
      begin
        $display("FAILED time %0t: fetch_rsp expected valid data %h actual valid %0b data %h",
                 $time, held_data, fetch_rsp.valid, fetch_rsp.data);
        data_errors++;
      end

      // Busy while clearing, and while a request waits for acceptance of its response
      exp_stall = (init_left > 0) ||
                  ((q_addr.size() != 0) && !(fetch_rsp.valid && ready));
      if (stall !== exp_stall)
      begin
        $display("FAILED time %0t: stall expected %0b actual %0b", $time, exp_stall, stall);
        protocol_errors++;
      end
      if (init_left > 0)
        init_left--;

      if (wb_o.stb && !wb_o.cyc)
      begin
        $display("Time %0t: bus strobe raised without a cycle", $time);
        protocol_errors++;
      end
      if (wb_o.cyc && wb_o.stb && wb_i.ack)
      begin
        if (fill_left == 0)
        begin
          $display("Time %0t: bus read of %h with no miss outstanding", $time, wb_o.adr);
          bus_errors++;
        end
        else
        begin
          if (wb_o.adr !== fill_base + LINE_BYTES - 4 * fill_left)
          begin
            $display("FAILED time %0t: wb_o.adr expected %h actual %h",
                     $time, fill_base + LINE_BYTES - 4 * fill_left, wb_o.adr);
            bus_errors++;
          end
          fill_left--;
        end
      end

      if (fetch_rsp.valid && ready)
      begin
        if (q_addr.size() == 0)
        begin
          $display("Time %0t: response accepted with no request pending", $time);
          protocol_errors++;
        end
        else
        begin
          rsp_addr = q_addr.pop_front();
          rsp_hit  = q_hit.pop_front();
          if (fetch_rsp.data !== expected_data(rsp_addr))
          begin
            $display("FAILED time %0t: fetch_rsp.data expected %h actual %h",
                     $time, expected_data(rsp_addr), fetch_rsp.data);
            data_errors++;
          end
          if (!rsp_hit && (fill_left != 0))
          begin
            $display("Time %0t: line fill for %h answered with %0d words still unread",
                     $time, rsp_addr, fill_left);
            bus_errors++;
            fill_left = 0;
          end
        end
      end

      if (fetch_req.valid && !stall)
      begin
        set_idx  = fetch_req.addr.raw[LOW_BITS +: `ICACHE_INDEX_BITS];
        line_tag = fetch_req.addr.raw >> (LOW_BITS + `ICACHE_INDEX_BITS);
        hit      = 1'b0;
        way      = 0;
        for (int w = 0; w < 4; w++)
          if (sh_valid[set_idx][w] && (sh_tag[set_idx][w] == line_tag))
          begin
            hit = 1'b1;
            way = w;
          end
        if (!hit)
        begin
          way                    = pick_victim(sh_valid[set_idx], sh_lru[set_idx]);
          sh_valid[set_idx][way] = 1'b1;
          sh_tag[set_idx][way]   = line_tag;
          fill_base              = {fetch_req.addr.raw[31:LOW_BITS], {LOW_BITS{1'b0}}};
          fill_left              = `ICACHE_LINE_WORDS;
        end
        sh_lru[set_idx] = lru_after_use(sh_lru[set_idx], way);  // Replay after a fill hits too
        q_addr.push_back(fetch_req.addr.raw);
        q_hit.push_back(hit);
        latency_check = 1'b1;
        latency_hit   = hit;
      end
      hold_pending = fetch_rsp.valid && !ready;
      held_data    = fetch_rsp.data;
    end
    outstanding = q_addr.size();
  end

endmodule

//--- tb_icache.sv
`timescale 1ns/10ps
`include "icache_settings.svh"

module tb_icache;

  localparam logic [31:0] DATA_PATTERN = 32'hA5C3_0F96;
  localparam int          LINE_BYTES   = 4 * `ICACHE_LINE_WORDS;
  localparam int          SET_STRIDE   = LINE_BYTES * `ICACHE_SETS;  // Same set, next tag
  localparam int          WAIT_LIMIT   = 200;

  logic                   clk;
  logic                   rst;
  icache_pkg::fetch_req_t fetch_req;
  logic                   ready;
  icache_pkg::fetch_rsp_t fetch_rsp;
  logic                   stall;
  icache_pkg::wb_m2s_t    wb_o;
  icache_pkg::wb_s2m_t    wb_i;
  logic                   random_ready;
  int                     wait_left;
  int                     timeouts;
  int                     seed;
  int                     data_errors;
  int                     hit_errors;
  int                     bus_errors;
  int                     protocol_errors;
  int                     outstanding;
  int                     total;

  icache_top icache_top_inst (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .ready(ready),
    .fetch_rsp(fetch_rsp), .stall(stall), .wb_o(wb_o), .wb_i(wb_i)
  );

  icache_checker #(.DATA_PATTERN(DATA_PATTERN)) icache_checker_inst (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .ready(ready),
    .fetch_rsp(fetch_rsp), .stall(stall), .wb_o(wb_o), .wb_i(wb_i),
    .data_errors(data_errors), .hit_errors(hit_errors), .bus_errors(bus_errors),
    .protocol_errors(protocol_errors), .outstanding(outstanding)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    ready = 1'b1;
    forever
    begin
      @(posedge clk);
      #5;
      ready = !random_ready || ($urandom % 4 != 0);  // Low about one cycle in four
    end
  end

  // ==================================================
  // Wishbone memory model, 0 to 3 wait cycles per word
  // ==================================================
  initial
  begin
    wb_i      = '0;
    wait_left = -1;
    forever
    begin
      @(posedge clk);
      #5;
      if (wb_i.ack)
      begin
        wb_i.ack  = 1'b0;
        wait_left = -1;
      end
      else if (wb_o.cyc && wb_o.stb)
      begin
        if (wait_left < 0)
          wait_left = $urandom % 4;
        if (wait_left == 0)
        begin
          wb_i.ack = 1'b1;
          wb_i.dat = wb_o.adr ^ DATA_PATTERN;
        end
        else
          wait_left--;
      end
    end
  end

  task automatic fetch(input logic [31:0] addr);
    int waited;
    waited             = 0;
    fetch_req.valid    = 1'b1;
    fetch_req.addr.raw = addr;
    @(negedge clk);
    while (stall && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (stall)
    begin
      $display("Timeout at %0t: fetch of %h was never accepted", $time, addr);
      timeouts++;
    end
    @(posedge clk);
    #5;
    fetch_req.valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((outstanding != 0) && (waited < WAIT_LIMIT))
    begin
      @(posedge clk);
      #5;
      waited++;
    end
    if (outstanding != 0)
    begin
      $display("Timeout at %0t: %0d requests never got a response", $time, outstanding);
      timeouts++;
    end
  endtask

  function automatic logic [31:0] random_addr();
    int line;
    int word;
    line = $urandom % (6 * `ICACHE_SETS);  // Six tags compete per set
    word = $urandom % `ICACHE_LINE_WORDS;
    return 32'h0001_0000 + line * LINE_BYTES + word * 4;
  endfunction

  // ==================================================
  // Test sequence
  // ==================================================
  initial
  begin
    seed         = $urandom(11);
    rst          = 1'b1;
    fetch_req    = '0;
    random_ready = 1'b0;
    timeouts     = 0;
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;

    fetch(32'h0000_1004);  // Cold miss
    drain();
    repeat (3)
      for (int w = 0; w < `ICACHE_LINE_WORDS; w++)
        fetch(32'h0000_1000 + 4 * w);
    drain();

    for (int k = 0; k < 5; k++)
      fetch(32'h0000_2020 + k * SET_STRIDE);  // Five lines into set 2
    drain();
    for (int k = 0; k < 5; k++)
      fetch(32'h0000_2020 + k * SET_STRIDE);
    drain();

    random_ready = 1'b1;
    repeat (40)
      fetch(random_addr());
    drain();
    random_ready = 1'b0;

    for (int n = 0; n < 300; n++)
    begin
      fetch(random_addr());
      if ($urandom % 4 == 0)
        idle_cycles(1);
    end
    drain();
    idle_cycles(4);

    total = data_errors + hit_errors + bus_errors + protocol_errors + timeouts;
    $display("Errors: data %0d, hit/miss %0d, bus %0d, protocol %0d, timeout %0d",
             data_errors, hit_errors, bus_errors, protocol_errors, timeouts);
    if (total == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- icache.f
+incdir+.
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_lookup.sv
icache_control.sv
icache_line_fill.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_tag_store.sv
      - icache_data_store.sv
      - icache_lookup.sv
      - icache_control.sv
      - icache_line_fill.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_checker.sv
      - tb_icache.sv
